// File: hw/sc12_cfg.svh
// Settings address and sample component width macros for the 12-bit packer
`ifndef SC12_CFG_SVH
`define SC12_CFG_SVH

// Settings bus address of the SID override register
`define SC12_SET_ADDR 8'h00

// Component width on the input stream
`define SC12_IN_W 16

// Component width after rounding
`define SC12_OUT_W 12

`endif

// File: hw/chdr_pkg.sv
// CHDR line union, header struct, header sizes and length helper functions
`default_nettype none

package chdr_pkg;

   // Header sizes in bytes, plain and with VITA time
   localparam logic [15:0] CHDR_HDR_BYTES  = 16'd8;
   localparam logic [15:0] CHDR_TIME_BYTES = 16'd16;

   // Header view, flags at the top and SID in the low word
   typedef struct packed {
      logic [1:0]  pkt_type;
      logic        has_time;
      logic        eob;
      logic [11:0] seq;
      logic [15:0] len;
      logic [15:0] sid_src;
      logic [15:0] sid_dst;
   } chdr_hdr_t;

   // One line seen either as a header or as two Q/I pairs
   typedef union packed {
      chdr_hdr_t hdr;
      struct packed {
         logic [15:0] q0;
         logic [15:0] i0;
         logic [15:0] q1;
         logic [15:0] i1;
      } smp;
   } chdr_line_t;

   // Header length for the time flag
   function automatic logic [15:0] chdr_hdr_bytes(input logic has_time);
      return has_time ? CHDR_TIME_BYTES : CHDR_HDR_BYTES;
   endfunction

   // Payload bytes behind the header
   function automatic logic [15:0] chdr_pay_bytes(input chdr_hdr_t h);
      return h.len - chdr_hdr_bytes(h.has_time);
   endfunction

endpackage

`default_nettype wire

// File: hw/sample_pkg.sv
// Signed sample component types, saturation limits and rounding constants
`include "sc12_cfg.svh"
`default_nettype none

package sample_pkg;

   // Component as carried on the input stream
   typedef logic signed [`SC12_IN_W-1:0] s16_t;

   // Component after rounding
   typedef logic signed [`SC12_OUT_W-1:0] s12_t;

   // Clamp values for positive and negative overflow
   localparam s12_t S12_MAX = 12'sh7FF;
   localparam s12_t S12_MIN = 12'sh800;

   // Number of LSBs dropped by the conversion
   localparam int RND_SHIFT = `SC12_IN_W - `SC12_OUT_W;

   // Half of the dropped range, added before truncation
   localparam int RND_HALF = 1 << (RND_SHIFT - 1);

endpackage

`default_nettype wire

// File: hw/sid_setting_reg.sv
// Settings bus register holding the SID override enable and destination
`timescale 1ns/1ps
`include "sc12_cfg.svh"
`default_nettype none

module sid_setting_reg #(
   // Own address on the shared settings bus
   parameter logic [7:0] ADDR = `SC12_SET_ADDR
) (
   input  wire         clk,
   input  wire         reset,
   input  wire         i_set_stb,
   input  wire  [7:0]  i_set_addr,
   input  wire  [31:0] i_set_data,
   output logic        o_sid_en,
   output logic [15:0] o_sid_dst
);

   logic wr_hit;

   // Write strobe qualified by address match
   assign wr_hit = i_set_stb && (i_set_addr == ADDR);

   always_ff @(posedge clk) begin
      if (reset) begin
         // Override off until software turns it on
         o_sid_en  <= 1'b0;
         o_sid_dst <= 16'd0;
      end else if (wr_hit) begin
         // Bit 16 enables, low half is the new destination
         o_sid_en  <= i_set_data[16];
         o_sid_dst <= i_set_data[15:0];
      end
   end

endmodule

`default_nettype wire

// File: hw/sample_round_sat.sv
// Round-half-up of one 16-bit Q/I pair to 12 bits with saturation
`timescale 1ns/1ps
`include "sc12_cfg.svh"
`default_nettype none

module sample_round_sat (
   input  wire sample_pkg::s16_t i_q,
   input  wire sample_pkg::s16_t i_i,
   output sample_pkg::s12_t      o_q,
   output sample_pkg::s12_t      o_i
);
   import sample_pkg::*;

   // One guard bit above the input for overflow detection
   localparam int SUM_W = `SC12_IN_W + 1;

   function automatic s12_t round_sat(input s16_t x);
      logic signed [SUM_W-1:0] sum;
      // Sign extend, then add half an output LSB
      sum = {x[`SC12_IN_W-1], x} + SUM_W'(RND_HALF);
      // Top two bits differ only on overflow
      case (sum[SUM_W-1 -: 2])
         2'b01:   round_sat = S12_MAX;
         2'b10:   round_sat = S12_MIN;
         default: round_sat = sum[`SC12_IN_W-1 -: `SC12_OUT_W];
      endcase
   endfunction

   // Both components through the same rounding path
   assign o_q = round_sat(i_q);
   assign o_i = round_sat(i_i);

endmodule

`default_nettype wire

// File: hw/chdr_16sc_to_12sc.sv
// CHDR 16-bit to 12-bit sample converter with header rewrite and repacking FSM
`timescale 1ns/1ps
`default_nettype none

module chdr_16sc_to_12sc (
   input  wire                       clk,
   input  wire                       reset,
   // SID override from the settings register
   input  wire                       i_sid_en,
   input  wire [15:0]                i_sid_dst,
   // Input stream
   input  wire chdr_pkg::chdr_line_t i_tdata,
   input  wire                       i_tlast,
   input  wire                       i_tvalid,
   output logic                      o_tready,
   // Output stream
   output chdr_pkg::chdr_line_t      o_tdata,
   output logic                      o_tlast,
   output logic                      o_tvalid,
   input  wire                       i_tready
);
   import chdr_pkg::*;
   import sample_pkg::*;

   // Packet FSM states, SAMPLE1..4 cycle over groups of four input lines
   localparam logic [2:0] HEADER  = 3'd0;
   localparam logic [2:0] TIME    = 3'd1;
   localparam logic [2:0] SAMPLE1 = 3'd2;
   localparam logic [2:0] SAMPLE2 = 3'd3;
   localparam logic [2:0] SAMPLE3 = 3'd4;
   localparam logic [2:0] SAMPLE4 = 3'd5;

   logic [2:0]  state;
   logic [2:0]  smp_next;
   logic        needs_extra;
   logic        in_extra;

   // Header length math
   logic [15:0] hdr_len;
   logic [15:0] pay_in;
   logic [17:0] pay_x3;
   logic [15:0] new_len;
   logic        has_extra;
   chdr_hdr_t   hdr_out;

   // Rounded, current and held components
   s12_t        r_q0;
   s12_t        r_i0;
   s12_t        r_q1;
   s12_t        r_i1;
   s12_t        c_q0;
   s12_t        c_i0;
   s12_t        c_q1;
   s12_t        c_i1;
   s12_t        h_q0;
   s12_t        h_i0;
   s12_t        h_q1;
   s12_t        h_i1;

   // Handshake helpers
   logic        xfer_in;
   logic        absorb;
   logic        go_extra;

   // Header sizes, only meaningful while in HEADER
   assign hdr_len = chdr_hdr_bytes(i_tdata.hdr.has_time);
   assign pay_in  = chdr_pay_bytes(i_tdata.hdr);

   // Output payload is three quarters of input payload
   assign pay_x3  = 18'(pay_in) * 18'd3;
   assign new_len = hdr_len + pay_x3[17:2];

   // Leftover of 12, 16 or 24 bytes per 32 needs a drain line after tlast
   assign has_extra = (pay_in[4:2] == 3'd3) || (pay_in[4:2] == 3'd4) || (pay_in[4:2] == 3'd6);

   // One rounding block per sample pair of the line
   sample_round_sat u_round_0 (
      .i_q (i_tdata.smp.q0),
      .i_i (i_tdata.smp.i0),
      .o_q (r_q0),
      .o_i (r_i0)
   );

   sample_round_sat u_round_1 (
      .i_q (i_tdata.smp.q1),
      .i_i (i_tdata.smp.i1),
      .o_q (r_q1),
      .o_i (r_i1)
   );

   // No input during the drain line, so keep its unused bits at zero
   assign c_q0 = in_extra ? '0 : r_q0;
   assign c_i0 = in_extra ? '0 : r_i0;
   assign c_q1 = in_extra ? '0 : r_q1;
   assign c_i1 = in_extra ? '0 : r_i1;

   assign xfer_in = i_tvalid && o_tready;

   // First line of a group produces nothing unless it ends the packet
   assign absorb = (state == SAMPLE1) && !i_tlast;

   // Last input line that still leaves samples to drain
   assign go_extra = needs_extra && i_tlast && ((state == SAMPLE2) || (state == SAMPLE3));

   // Ready passes through, except when absorbing or draining
   assign o_tready = !in_extra && (absorb || i_tready);
   assign o_tvalid = in_extra || (i_tvalid && !absorb);
   assign o_tlast  = in_extra || (i_tlast && !go_extra);

   // Successor within the four-line sample cycle
   always_comb begin
      case (state)
         SAMPLE1: smp_next = SAMPLE2;
         SAMPLE2: smp_next = SAMPLE3;
         SAMPLE3: smp_next = SAMPLE4;
         default: smp_next = SAMPLE1;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= HEADER;
         needs_extra <= 1'b0;
         in_extra    <= 1'b0;
      end else if (in_extra) begin
         // Drain line leaves once the sink takes it
         if (i_tready) begin
            state    <= HEADER;
            in_extra <= 1'b0;
         end
      end else if (xfer_in) begin
         case (state)
            HEADER: begin
               needs_extra <= has_extra;
               // Header-only packet stays here
               if (i_tlast) begin
                  state <= HEADER;
               end else if (i_tdata.hdr.has_time) begin
                  state <= TIME;
               end else begin
                  state <= SAMPLE1;
               end
            end
            TIME: begin
               state <= i_tlast ? HEADER : SAMPLE1;
            end
            SAMPLE1, SAMPLE2, SAMPLE3, SAMPLE4: begin
               if (go_extra) begin
                  state    <= smp_next;
                  in_extra <= 1'b1;
               end else if (i_tlast) begin
                  state <= HEADER;
               end else begin
                  state <= smp_next;
               end
            end
            default: begin
               state <= HEADER;
            end
         endcase
      end
   end

   // Previous line's components for the next packed line
   always_ff @(posedge clk) begin
      if (xfer_in) begin
         h_q0 <= r_q0;
         h_i0 <= r_i0;
         h_q1 <= r_q1;
         h_i1 <= r_i1;
      end
   end

   always_comb begin
      // Header with new length and optional destination
      hdr_out     = i_tdata.hdr;
      hdr_out.len = new_len;
      if (i_sid_en) begin
         hdr_out.sid_dst = i_sid_dst;
      end
      case (state)
         HEADER: o_tdata.hdr = hdr_out;
         // VITA time unchanged
         TIME:   o_tdata = i_tdata;
         // Only seen as a short final line
         SAMPLE1: o_tdata = chdr_line_t'({c_q0, c_i0, c_q1, c_i1, 16'd0});
         // Three-line repeating 12-bit pattern
         SAMPLE2: o_tdata = chdr_line_t'({h_q0, h_i0, h_q1, h_i1, c_q0, c_i0[11:8]});
         SAMPLE3: o_tdata = chdr_line_t'({h_i0[7:0], h_q1, h_i1, c_q0, c_i0, c_q1[11:4]});
         SAMPLE4: o_tdata = chdr_line_t'({h_q1[3:0], h_i1, c_q0, c_i0, c_q1, c_i1});
         default: o_tdata = i_tdata;
      endcase
   end

endmodule

`default_nettype wire

// File: hw/sc12_pack_top.sv
// Top level joining the SID settings register and the 16-to-12 bit converter
`timescale 1ns/1ps
`default_nettype none

module sc12_pack_top (
   input  wire                       clk,
   input  wire                       reset,
   // Settings bus
   input  wire                       i_set_stb,
   input  wire [7:0]                 i_set_addr,
   input  wire [31:0]                i_set_data,
   // Input stream
   input  wire chdr_pkg::chdr_line_t i_tdata,
   input  wire                       i_tlast,
   input  wire                       i_tvalid,
   output logic                      o_tready,
   // Output stream
   output chdr_pkg::chdr_line_t      o_tdata,
   output logic                      o_tlast,
   output logic                      o_tvalid,
   input  wire                       i_tready
);

   // Override from register to converter
   logic        sid_en;
   logic [15:0] sid_dst;

   sid_setting_reg u_sid_setting_reg (
      .clk        (clk),
      .reset      (reset),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .o_sid_en   (sid_en),
      .o_sid_dst  (sid_dst)
   );

   // Stream path, no added latency here
   chdr_16sc_to_12sc u_chdr_16sc_to_12sc (
      .clk       (clk),
      .reset     (reset),
      .i_sid_en  (sid_en),
      .i_sid_dst (sid_dst),
      .i_tdata   (i_tdata),
      .i_tlast   (i_tlast),
      .i_tvalid  (i_tvalid),
      .o_tready  (o_tready),
      .o_tdata   (o_tdata),
      .o_tlast   (o_tlast),
      .o_tvalid  (o_tvalid),
      .i_tready  (i_tready)
   );

endmodule

`default_nettype wire

// File: sim/tb_sc12_pack.sv
// Testbench for sc12_pack_top with stimulus, packing reference, comparator and watchdog
`timescale 1ns/1ps
`include "sc12_cfg.svh"
`default_nettype none

module tb_sc12_pack;
   import chdr_pkg::*;

   localparam logic [31:0] SEED = 32'hc38b;
   // 50 packets of at most 10 lines, 20 cycles allowed per line
   localparam int NUM_PKTS        = 50;
   localparam int MAX_PKT_LINES   = 10;
   localparam int WATCHDOG_CYCLES = NUM_PKTS * MAX_PKT_LINES * 20;

   logic        clk = 1'b0;
   logic        reset;
   logic        i_set_stb;
   logic [7:0]  i_set_addr;
   logic [31:0] i_set_data;
   chdr_line_t  i_tdata;
   logic        i_tlast;
   logic        i_tvalid;
   logic        o_tready;
   chdr_line_t  o_tdata;
   logic        o_tlast;
   logic        o_tvalid;
   logic        i_tready = 1'b1;

   // Expected output lines, compare mask and last flag
   logic [63:0] exp_data[$];
   logic [63:0] exp_mask[$];
   logic        exp_last[$];

   logic [63:0] pkt_smp [8];
   logic [31:0] rnd_state   = SEED;
   logic [31:0] stall_state = ~SEED;
   logic        stall_en    = 1'b0;
   logic        gaps_en     = 1'b0;
   logic        model_sid_en  = 1'b0;
   logic [15:0] model_sid_dst = 16'd0;
   int          pkt_cnt       = 0;
   int          errors        = 0;
   int          lines_checked = 0;

   sc12_pack_top u_sc12_pack_top (
      .clk        (clk),
      .reset      (reset),
      .i_set_stb  (i_set_stb),
      .i_set_addr (i_set_addr),
      .i_set_data (i_set_data),
      .i_tdata    (i_tdata),
      .i_tlast    (i_tlast),
      .i_tvalid   (i_tvalid),
      .o_tready   (o_tready),
      .o_tdata    (o_tdata),
      .o_tlast    (o_tlast),
      .o_tvalid   (o_tvalid),
      .i_tready   (i_tready)
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] rand_next();
      rnd_state = xorshift32(rnd_state);
      return rnd_state;
   endfunction

   // Values around the clamp and rounding boundaries
   function automatic logic [15:0] full_scale_value(input logic [31:0] r);
      case (r[2:0])
         3'd0:    return 16'h7FFF;
         3'd1:    return 16'h7FF8;
         3'd2:    return 16'h7FF7;
         3'd3:    return 16'h8000;
         3'd4:    return 16'h8001;
         3'd5:    return 16'h8008;
         3'd6:    return 16'hFFF8;
         default: return 16'h0008;
      endcase
   endfunction

   // Round half up by floor of (x + 8) / 16, then clamp to 12 bits
   function automatic logic [11:0] round12(input logic [15:0] x);
      int v;
      v = int'($signed(x));
      v = (v + 8) >>> 4;
      if (v > 2047) v = 2047;
      if (v < -2048) v = -2048;
      return 12'(v);
   endfunction

   function automatic void queue_expected(input logic [63:0] d, input logic [63:0] m,
                                          input logic l);
      exp_data.push_back(d);
      exp_mask.push_back(m);
      exp_last.push_back(l);
   endfunction

   // Reference packet: header, optional time, samples packed MSB first
   function automatic void build_expected(input chdr_hdr_t h, input logic [63:0] t_line,
                                          input int n);
      chdr_hdr_t    eh;
      logic [383:0] stream;
      int           i;
      int           c;
      int           lines;
      int           vb;
      eh = h;
      // Three quarters of the payload behind the same header size
      eh.len = (h.has_time ? CHDR_TIME_BYTES : CHDR_HDR_BYTES) + 16'(6 * n);
      if (model_sid_en) eh.sid_dst = model_sid_dst;
      queue_expected(eh, ~64'd0, 1'b0);
      if (h.has_time) queue_expected(t_line, ~64'd0, 1'b0);
      stream = '0;
      for (i = 0; i < n; i++) begin
         for (c = 0; c < 4; c++) begin
            stream[383 - 12 * (4 * i + c) -: 12] = round12(pkt_smp[i][63 - 16 * c -: 16]);
         end
      end
      lines = (6 * n + 7) / 8;
      // Bytes actually covered in the final line
      vb = 6 * n - 8 * (lines - 1);
      for (i = 0; i < lines; i++) begin
         queue_expected(stream[383 - 64 * i -: 64],
                        (i == lines - 1) ? (~64'd0 << (64 - 8 * vb)) : ~64'd0,
                        i == lines - 1);
      end
   endfunction

   task automatic send_line(input logic [63:0] data, input logic last);
      int gap;
      gap = gaps_en ? int'(rand_next() % 32'd3) : 0;
      @(negedge clk);
      if (gap > 0) begin
         i_tvalid = 1'b0;
         i_tlast  = 1'b0;
         repeat (gap) @(negedge clk);
      end
      i_tdata  = chdr_line_t'(data);
      i_tlast  = last;
      i_tvalid = 1'b1;
      // Hold until the DUT takes the line
      @(posedge clk);
      while (!o_tready) @(posedge clk);
   endtask

   task automatic send_packet(input logic has_time, input int n, input logic full_scale);
      chdr_hdr_t   h;
      logic [63:0] t_line;
      logic [31:0] r;
      int          k;
      r          = rand_next();
      h.pkt_type = 2'b00;
      h.has_time = has_time;
      h.eob      = 1'b0;
      h.seq      = 12'(pkt_cnt);
      h.len      = (has_time ? CHDR_TIME_BYTES : CHDR_HDR_BYTES) + 16'(8 * n);
      h.sid_src  = r[31:16];
      h.sid_dst  = r[15:0];
      t_line     = {rand_next(), rand_next()};
      for (k = 0; k < n; k++) begin
         if (full_scale) begin
            pkt_smp[k] = {full_scale_value(rand_next()), full_scale_value(rand_next()),
                          full_scale_value(rand_next()), full_scale_value(rand_next())};
         end else begin
            pkt_smp[k] = {rand_next(), rand_next()};
         end
      end
      build_expected(h, t_line, n);
      pkt_cnt++;
      send_line(h, 1'b0);
      if (has_time) send_line(t_line, 1'b0);
      for (k = 0; k < n; k++) send_line(pkt_smp[k], k == n - 1);
   endtask

   // Register model follows only writes to its own address
   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      @(negedge clk);
      i_set_stb  = 1'b1;
      i_set_addr = addr;
      i_set_data = data;
      @(negedge clk);
      i_set_stb = 1'b0;
      if (addr == `SC12_SET_ADDR) begin
         model_sid_en  = data[16];
         model_sid_dst = data[15:0];
      end
   endtask

   task automatic wait_drain();
      @(negedge clk);
      i_tvalid = 1'b0;
      i_tlast  = 1'b0;
      while (exp_data.size() != 0) @(posedge clk);
      repeat (2) @(negedge clk);
   endtask

   // Sink ready, stalls about one cycle in four when enabled
   always @(negedge clk) begin
      stall_state = xorshift32(stall_state);
      if (stall_en) begin
         i_tready = (stall_state[1:0] != 2'b00);
      end else begin
         i_tready = 1'b1;
      end
   end

   always @(posedge clk) begin : compare_out
      logic [63:0] got;
      logic [63:0] want;
      logic [63:0] mask;
      logic        want_last;
      if (!reset && o_tvalid && i_tready) begin
         got = o_tdata;
         if (exp_data.size() == 0) begin
            $display("Output line %h at %0t arrived with no line left in the model", got, $time);
            errors++;
         end else begin
            want      = exp_data.pop_front();
            mask      = exp_mask.pop_front();
            want_last = exp_last.pop_front();
            if ((got & mask) !== (want & mask)) begin
               $display("Fail %0t: data %h, expected %h under mask %h", $time, got, want, mask);
               errors++;
            end
            if (o_tlast !== want_last) begin
               $display("Fail %0t: tlast %b, expected %b", $time, o_tlast, want_last);
               errors++;
            end
            lines_checked++;
         end
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Watchdog expired after %0d cycles with %0d expected lines never seen",
               WATCHDOG_CYCLES, exp_data.size());
      $display("Summary: %0d lines checked, %0d errors", lines_checked, errors);
      $display("TEST FAILED");
      $finish;
   end

   initial begin : main
      int n;
      reset      = 1'b1;
      i_set_stb  = 1'b0;
      i_set_addr = 8'd0;
      i_set_data = 32'd0;
      i_tdata    = '0;
      i_tlast    = 1'b0;
      i_tvalid   = 1'b0;
      repeat (2) @(negedge clk);
      reset = 1'b0;
      // Plain headers, every payload length from 8 to 64 bytes
      for (n = 1; n <= 8; n++) send_packet(1'b0, n, 1'b0);
      wait_drain();
      // Time line present
      for (n = 1; n <= 8; n++) send_packet(1'b1, n, 1'b0);
      wait_drain();
      // Samples at the rounding and clamp edges
      for (n = 0; n < 6; n++) send_packet(1'b0, int'(rand_next() % 32'd8) + 1, 1'b1);
      wait_drain();
      // SID override on, then a write elsewhere on the bus
      write_setting(`SC12_SET_ADDR, 32'h0001_A5C3);
      send_packet(1'b0, 3, 1'b0);
      send_packet(1'b1, 4, 1'b0);
      wait_drain();
      write_setting(8'h5A, 32'h0001_BEEF);
      send_packet(1'b0, 2, 1'b0);
      send_packet(1'b1, 7, 1'b0);
      wait_drain();
      // Back-pressure and input gaps
      stall_en = 1'b1;
      gaps_en  = 1'b1;
      for (n = 0; n < 24; n++) begin
         send_packet(rnd_state[0], int'(rand_next() % 32'd8) + 1, rnd_state[5]);
      end
      wait_drain();
      $display("Summary: %0d packets, %0d lines checked, %0d errors",
               pkt_cnt, lines_checked, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
+incdir+hw
hw/chdr_pkg.sv
hw/sample_pkg.sv
hw/sid_setting_reg.sv
hw/sample_round_sat.sv
hw/chdr_16sc_to_12sc.sv
hw/sc12_pack_top.sv
sim/tb_sc12_pack.sv

// File: Makefile
# Verilator build and run of the 16-to-12 bit sample packer testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f list.f --top-module tb_sc12_pack -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_sc12_pack); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
